// File: design/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

	// Data and address word
	typedef logic [31:0] word_t;

	// Register file index
	typedef logic [4:0] regIdx_t;

	// Instruction fields
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// R-type and jump opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_J     = 6'h02;

	// Branch opcodes
	localparam opcode_t OP_BEQ   = 6'h04;
	localparam opcode_t OP_BNE   = 6'h05;

	// Immediate opcodes
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_SLTI  = 6'h0A;
	localparam opcode_t OP_ANDI  = 6'h0C;
	localparam opcode_t OP_ORI   = 6'h0D;
	localparam opcode_t OP_XORI  = 6'h0E;
	localparam opcode_t OP_LUI   = 6'h0F;

	// Memory opcodes
	localparam opcode_t OP_LW    = 6'h23;
	localparam opcode_t OP_SW    = 6'h2B;

	// R-type funct codes
	localparam funct_t FN_ADD    = 6'h20;
	localparam funct_t FN_SUB    = 6'h22;
	localparam funct_t FN_AND    = 6'h24;
	localparam funct_t FN_OR     = 6'h25;
	localparam funct_t FN_XOR    = 6'h26;
	localparam funct_t FN_SLT    = 6'h2A;

	// ALU function select, four bits
	typedef enum logic [3:0] {
		ALU_AND = 4'h0,
		ALU_OR  = 4'h1,
		ALU_ADD = 4'h2,
		ALU_XOR = 4'h4,
		ALU_SUB = 4'h6,
		ALU_SLT = 4'h7,
		ALU_LUI = 4'h8
	} aluCtrl_t;

	// First fetch address out of reset
	localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

// File: design/mipsCtrlPkg.sv
`default_nettype none

package mipsCtrlPkg;

	import mipsIsaPkg::*;

	// Sequencer states
	typedef enum logic [3:0] {
		S_FETCH    = 4'd0,
		S_DECODE   = 4'd1,
		S_MEMADR   = 4'd2,
		S_MEMREAD  = 4'd3,
		S_MEMWB    = 4'd4,
		S_MEMWRITE = 4'd5,
		S_EXECUTE  = 4'd6,
		S_ALUWB    = 4'd7,
		S_BRANCH   = 4'd8,
		S_IEXECUTE = 4'd9,
		S_IWB      = 4'd10,
		S_JUMP     = 4'd11,
		S_PREFETCH = 4'd12
	} ctrlState_t;

	// Request from sequencer to ALU decoder
	typedef enum logic [1:0] {AOP_ADD, AOP_SUB, AOP_FUNCT, AOP_IMM} aluOp_t;

	// Operand and PC multiplexer selects
	typedef enum logic [1:0] {SRCA_PC, SRCA_REG} srcA_t;
	typedef enum logic [1:0] {SRCB_REG, SRCB_FOUR, SRCB_IMM, SRCB_BROFF} srcB_t;
	typedef enum logic [1:0] {PCSRC_ALU, PCSRC_ALUOUT, PCSRC_JUMP} pcSrc_t;

	// Everything the datapath needs per cycle
	typedef struct packed {
		logic     memToReg;
		logic     iOrD;
		logic     regDst;
		pcSrc_t   pcSrc;
		srcA_t    aluSrcA;
		srcB_t    aluSrcB;
		// Bit 1 bne, bit 0 beq
		logic [1:0] branch;
		logic     irWrite;
		logic     memWrite;
		logic     pcWrite;
		logic     regWrite;
		logic     extOp;
		aluCtrl_t aluControl;
	} ctrlBundle_t;

endpackage

`default_nettype wire

// File: design/aluDecoder.sv
`default_nettype none

module aluDecoder import mipsIsaPkg::*, mipsCtrlPkg::*; (
	input  aluOp_t   aluOp,
	input  funct_t   funct,
	input  opcode_t  opcode,
	output aluCtrl_t aluControl
);

	always_comb begin
		aluControl = ALU_ADD;
		case (aluOp)
			AOP_ADD: aluControl = ALU_ADD;
			// Branch compare
			AOP_SUB: aluControl = ALU_SUB;
			// R-type, by funct
			AOP_FUNCT: begin
				case (funct)
					FN_ADD:  aluControl = ALU_ADD;
					FN_SUB:  aluControl = ALU_SUB;
					FN_AND:  aluControl = ALU_AND;
					FN_OR:   aluControl = ALU_OR;
					FN_XOR:  aluControl = ALU_XOR;
					FN_SLT:  aluControl = ALU_SLT;
					default: aluControl = ALU_ADD;
				endcase
			end
			// Immediates, by opcode
			AOP_IMM: begin
				case (opcode)
					OP_ADDI: aluControl = ALU_ADD;
					OP_SLTI: aluControl = ALU_SLT;
					OP_ANDI: aluControl = ALU_AND;
					OP_ORI:  aluControl = ALU_OR;
					OP_XORI: aluControl = ALU_XOR;
					OP_LUI:  aluControl = ALU_LUI;
					default: aluControl = ALU_ADD;
				endcase
			end
			default: aluControl = ALU_ADD;
		endcase
	end

endmodule

`default_nettype wire

// File: design/alu.sv
`default_nettype none

module alu import mipsIsaPkg::*; (
	input  word_t    a,
	input  word_t    b,
	input  aluCtrl_t aluControl,
	output word_t    result,
	output logic     zero
);

	always_comb begin
		case (aluControl)
			ALU_ADD: begin
				result = a + b;
			end
			ALU_SUB: begin
				result = a - b;
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			ALU_XOR: begin
				result = a ^ b;
			end
			// Signed compare, one in bit 0
			ALU_SLT: begin
				result = {31'b0, $signed(a) < $signed(b)};
			end
			// Immediate into the upper half, a unused
			ALU_LUI: begin
				result = {b[15:0], 16'h0000};
			end
			default: begin
				result = a + b;
			end
		endcase
	end

	// Equality test for branches
	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: design/registerFile.sv
`default_nettype none

module registerFile import mipsIsaPkg::*; (
	input  logic    cclk,
	input  regIdx_t ra1,
	input  regIdx_t ra2,
	input  regIdx_t wa,
	input  word_t   wd,
	input  logic    we,
	output word_t   rd1,
	output word_t   rd2
);

	word_t regs [32];

	// Write port, $zero never stored
	always_ff @(posedge cclk) begin
		if (we && (wa != 5'd0)) begin
			regs[wa] <= wd;
		end
	end

	// Read ports, $zero forced
	assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// File: design/controlUnit.sv
`default_nettype none

module controlUnit import mipsIsaPkg::*, mipsCtrlPkg::*; (
	input  logic        cclk,
	input  logic        rstb,
	input  opcode_t     opcode,
	input  funct_t      funct,
	output ctrlBundle_t ctrl
);

	ctrlState_t state;
	ctrlState_t nextState;
	aluOp_t     aluOp;
	aluCtrl_t   aluControl;
	logic       zeroExt;

	// Logical immediates take the zero-extended form
	assign zeroExt = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);

	// Funct in R-type execute, opcode in immediate execute
	always_comb begin
		case (state)
			S_EXECUTE:  aluOp = AOP_FUNCT;
			S_IEXECUTE: aluOp = AOP_IMM;
			S_BRANCH:   aluOp = AOP_SUB;
			default:    aluOp = AOP_ADD;
		endcase
	end

	aluDecoder aluDecoder_i (
		.aluOp      (aluOp),
		.funct      (funct),
		.opcode     (opcode),
		.aluControl (aluControl)
	);

	// State register
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= S_PREFETCH;
		end else begin
			state <= nextState;
		end
	end

	// Sequencing
	always_comb begin
		nextState = S_PREFETCH;
		case (state)
			S_PREFETCH: nextState = S_FETCH;
			S_FETCH:    nextState = S_DECODE;
			S_DECODE: begin
				case (opcode)
					OP_LW, OP_SW:   nextState = S_MEMADR;
					OP_RTYPE:       nextState = S_EXECUTE;
					OP_BEQ, OP_BNE: nextState = S_BRANCH;
					OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
						nextState = S_IEXECUTE;
					end
					OP_J:           nextState = S_JUMP;
					// Unknown opcode, back to fetch
					default:        nextState = S_PREFETCH;
				endcase
			end
			S_MEMADR:   nextState = (opcode == OP_LW) ? S_MEMREAD : S_MEMWRITE;
			S_MEMREAD:  nextState = S_MEMWB;
			S_EXECUTE:  nextState = S_ALUWB;
			S_IEXECUTE: nextState = S_IWB;
			// Writeback, store, branch and jump all end here
			default:    nextState = S_PREFETCH;
		endcase
	end

	// Control bundle per state
	always_comb begin
		// Defaults, nothing written
		ctrl.memToReg   = 1'b0;
		ctrl.iOrD       = 1'b0;
		ctrl.regDst     = 1'b0;
		ctrl.pcSrc      = PCSRC_ALU;
		ctrl.aluSrcA    = SRCA_PC;
		ctrl.aluSrcB    = SRCB_FOUR;
		ctrl.branch     = 2'b00;
		ctrl.irWrite    = 1'b0;
		ctrl.memWrite   = 1'b0;
		ctrl.pcWrite    = 1'b0;
		ctrl.regWrite   = 1'b0;
		ctrl.extOp      = !zeroExt;
		ctrl.aluControl = aluControl;
		case (state)
			// Load IR from mem[PC], PC plus four
			S_PREFETCH: begin
				ctrl.irWrite = 1'b1;
				ctrl.pcWrite = 1'b1;
			end
			// IR keeps the prefetched word
			S_FETCH: begin
				ctrl.irWrite = 1'b0;
			end
			// Branch target into ALU out while registers are read
			S_DECODE: begin
				ctrl.aluSrcB = SRCB_BROFF;
			end
			// Base plus offset
			S_MEMADR: begin
				ctrl.aluSrcA = SRCA_REG;
				ctrl.aluSrcB = SRCB_IMM;
			end
			S_MEMREAD: begin
				ctrl.iOrD = 1'b1;
			end
			// Loaded word into rt
			S_MEMWB: begin
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			// Single-cycle write strobe
			S_MEMWRITE: begin
				ctrl.iOrD     = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			S_EXECUTE: begin
				ctrl.aluSrcA = SRCA_REG;
				ctrl.aluSrcB = SRCB_REG;
			end
			// Result into rd
			S_ALUWB: begin
				ctrl.regDst   = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			// Compare rs and rt, target already in ALU out
			S_BRANCH: begin
				ctrl.aluSrcA = SRCA_REG;
				ctrl.aluSrcB = SRCB_REG;
				ctrl.pcSrc   = PCSRC_ALUOUT;
				ctrl.branch  = {opcode == OP_BNE, opcode == OP_BEQ};
			end
			S_IEXECUTE: begin
				ctrl.aluSrcA = SRCA_REG;
				ctrl.aluSrcB = SRCB_IMM;
			end
			// Result into rt
			S_IWB: begin
				ctrl.regWrite = 1'b1;
			end
			S_JUMP: begin
				ctrl.pcSrc   = PCSRC_JUMP;
				ctrl.pcWrite = 1'b1;
			end
			default: begin
				ctrl.irWrite = 1'b0;
			end
		endcase
	end

	// Store strobe only in the store state, gone next cycle
	memWriteState: assert property (@(posedge cclk) disable iff (!rstb)
		ctrl.memWrite |-> state == S_MEMWRITE ##1 !ctrl.memWrite)
		else $error("memWrite outside S_MEMWRITE");

	// Register writes only in writeback, followed by a new fetch
	regWriteState: assert property (@(posedge cclk) disable iff (!rstb)
		ctrl.regWrite |-> state inside {S_MEMWB, S_ALUWB, S_IWB} ##1 state == S_PREFETCH)
		else $error("regWrite outside a writeback state");

	stateLegal: assert property (@(posedge cclk) disable iff (!rstb)
		!$isunknown(state) && state inside {S_PREFETCH, S_FETCH, S_DECODE, S_MEMADR,
			S_MEMREAD, S_MEMWB, S_MEMWRITE, S_EXECUTE, S_ALUWB, S_BRANCH,
			S_IEXECUTE, S_IWB, S_JUMP})
		else $error("illegal controller state");

endmodule

`default_nettype wire

// File: design/datapath.sv
`default_nettype none

module datapath import mipsIsaPkg::*, mipsCtrlPkg::*; (
	input  logic        cclk,
	input  logic        rstb,
	input  ctrlBundle_t ctrl,
	output opcode_t     opcode,
	output funct_t      funct,
	output word_t       memAddr,
	output word_t       memWriteData,
	output logic        memWrite,
	input  word_t       memReadData
);

	word_t   pc;
	word_t   instr;
	word_t   dataReg;
	word_t   aReg;
	word_t   bReg;
	word_t   aluOut;
	word_t   rd1;
	word_t   rd2;
	word_t   srcA;
	word_t   srcB;
	word_t   aluResult;
	word_t   immExt;
	word_t   brOff;
	word_t   jumpTarget;
	word_t   pcNext;
	word_t   writeData;
	regIdx_t writeReg;
	logic    zero;
	logic    pcEn;

	// Fields for the controller
	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	// Immediate forms
	assign immExt     = ctrl.extOp ? {{16{instr[15]}}, instr[15:0]} : {16'h0000, instr[15:0]};
	assign brOff      = {immExt[29:0], 2'b00};
	// PC already points past the jump
	assign jumpTarget = {pc[31:28], instr[25:0], 2'b00};

	// Memory side, instruction or data address
	assign memAddr      = ctrl.iOrD ? aluOut : pc;
	assign memWriteData = bReg;
	assign memWrite     = ctrl.memWrite;

	// Writeback select
	assign writeReg  = ctrl.regDst ? instr[15:11] : instr[20:16];
	assign writeData = ctrl.memToReg ? dataReg : aluOut;

	registerFile registerFile_i (
		.cclk (cclk),
		.ra1  (instr[25:21]),
		.ra2  (instr[20:16]),
		.wa   (writeReg),
		.wd   (writeData),
		.we   (ctrl.regWrite),
		.rd1  (rd1),
		.rd2  (rd2)
	);

	// ALU operands
	assign srcA = (ctrl.aluSrcA == SRCA_REG) ? aReg : pc;

	always_comb begin
		case (ctrl.aluSrcB)
			SRCB_REG:   srcB = bReg;
			SRCB_FOUR:  srcB = 32'd4;
			SRCB_IMM:   srcB = immExt;
			SRCB_BROFF: srcB = brOff;
			default:    srcB = 32'd4;
		endcase
	end

	alu alu_i (
		.a          (srcA),
		.b          (srcB),
		.aluControl (ctrl.aluControl),
		.result     (aluResult),
		.zero       (zero)
	);

	// Next PC source
	always_comb begin
		case (ctrl.pcSrc)
			PCSRC_ALUOUT: pcNext = aluOut;
			PCSRC_JUMP:   pcNext = jumpTarget;
			default:      pcNext = aluResult;
		endcase
	end

	// beq on zero, bne on nonzero
	assign pcEn = ctrl.pcWrite || (ctrl.branch[0] && zero) || (ctrl.branch[1] && !zero);

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			pc <= RESET_PC;
		end else if (pcEn) begin
			pc <= pcNext;
		end
	end

	// Instruction and pipeline-style holding registers
	always_ff @(posedge cclk) begin
		if (ctrl.irWrite) begin
			instr <= memReadData;
		end
		dataReg <= memReadData;
		aReg    <= rd1;
		bReg    <= rd2;
		aluOut  <= aluResult;
	end

	// Stores always go out on the computed address
	storeAddr: assert property (@(posedge cclk) disable iff (!rstb)
		ctrl.memWrite |-> ctrl.iOrD && !ctrl.irWrite && !pcEn)
		else $error("store strobe without data address");

endmodule

`default_nettype wire

// File: design/multicycleCpu.sv
`default_nettype none

module multicycleCpu import mipsIsaPkg::*, mipsCtrlPkg::*; (
	input  logic  cclk,
	input  logic  rstb,
	input  word_t memReadData,
	output word_t memAddr,
	output word_t memWriteData,
	output logic  memWrite
);

	ctrlBundle_t ctrl;
	opcode_t     opcode;
	funct_t      funct;

	// Sequencer, sees only instruction fields
	controlUnit controlUnit_i (
		.cclk   (cclk),
		.rstb   (rstb),
		.opcode (opcode),
		.funct  (funct),
		.ctrl   (ctrl)
	);

	// Registers, ALU and memory port
	datapath datapath_i (
		.cclk         (cclk),
		.rstb         (rstb),
		.ctrl         (ctrl),
		.opcode       (opcode),
		.funct        (funct),
		.memAddr      (memAddr),
		.memWriteData (memWriteData),
		.memWrite     (memWrite),
		.memReadData  (memReadData)
	);

endmodule

`default_nettype wire

// File: verif/memModel.sv
`default_nettype none

module memModel import mipsIsaPkg::*; (
	input  logic  cclk,
	input  word_t addr,
	input  word_t writeData,
	input  logic  writeEn,
	output word_t readData
);

	timeunit 1ns;
	timeprecision 1ps;

	// 256 words, byte address bits 9:2
	word_t mem [256];

	// Load port, used while the core sits in reset
	logic       loadEn = 1'b0;
	logic [7:0] loadIdx = '0;
	word_t      loadData = '0;

	// Combinational read, instruction and data alike
	assign readData = mem[addr[9:2]];

	// Load port wins over a core store
	always_ff @(posedge cclk) begin
		if (loadEn) begin
			mem[loadIdx] <= loadData;
		end else if (writeEn) begin
			mem[addr[9:2]] <= writeData;
		end
	end

	// One word per cycle, set up on the falling edge
	task automatic loadWord(input int idx, input word_t value);
		@(negedge cclk);
		loadEn   = 1'b1;
		loadIdx  = idx[7:0];
		loadData = value;
	endtask

	task automatic loadDone();
		@(negedge cclk);
		loadEn = 1'b0;
	endtask

endmodule

`default_nettype wire

// File: verif/cpuTb.sv
`default_nettype none

module cpuTb import mipsIsaPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MEM_WORDS     = 256;
	localparam int RESET_CYCLES  = 8;
	localparam int STORE_TIMEOUT = 200;
	localparam int MAX_STORES    = 32;
	// Cycles per class, fetch to next fetch
	localparam int CYC_ALU       = 5;
	localparam int CYC_SW        = 5;
	localparam word_t DATA_BASE  = 32'h0000_0200;
	localparam word_t DONE_ADDR  = 32'h0000_03FC;

	logic  cclk;
	logic  rstb;
	word_t memAddr;
	word_t memWriteData;
	word_t memReadData;
	logic  memWrite;

	// Program image and the stores it should produce
	word_t prog[$];
	word_t expAddr[$];
	word_t expData[$];

	int checks = 0;
	int mismatches = 0;
	int failures = 0;

	multicycleCpu multicycleCpu_i (
		.cclk         (cclk),
		.rstb         (rstb),
		.memReadData  (memReadData),
		.memAddr      (memAddr),
		.memWriteData (memWriteData),
		.memWrite     (memWrite)
	);

	memModel memModel_i (
		.cclk      (cclk),
		.addr      (memAddr),
		.writeData (memWriteData),
		.writeEn   (memWrite),
		.readData  (memReadData)
	);

	initial begin
		cclk = 1'b0;
		forever #10 cclk = ~cclk;
	end

	// ISA extension rules
	function automatic word_t signExtend(logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic word_t zeroExtend(logic [15:0] imm);
		return {16'h0000, imm};
	endfunction

	function automatic word_t setLess(word_t x, word_t y);
		return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
	endfunction

	// Unknown opcode 0x3F, a no-op if ever fetched
	function automatic word_t fillWord(int idx);
		return {6'h3F, 18'h00000, idx[7:0]};
	endfunction

	// Encoders take operands in assembly order
	function automatic word_t encodeR(funct_t fn, regIdx_t rd, regIdx_t rs, regIdx_t rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t encodeI(opcode_t op, regIdx_t rt, regIdx_t rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t encodeJ(logic [25:0] target);
		return {OP_J, target};
	endfunction

	task automatic checkWord(string what, word_t actual, word_t expected);
		checks++;
		if (actual !== expected) begin
			$display("MISMATCH %s: got %h, expected %h", what, actual, expected);
			mismatches++;
		end
	endtask

	task automatic checkAddr(string what, word_t actual, word_t expected);
		checks++;
		if (actual !== expected) begin
			$display("MISMATCH %s: got %h, expected %h", what, actual, expected);
			mismatches++;
		end
	endtask

	task automatic checkCycles(string what, int actual, int expected);
		checks++;
		if (actual != expected) begin
			$display("MISMATCH %s: got %h, expected %h", what, actual, expected);
			mismatches++;
		end
	endtask

	task automatic clearProgram();
		prog.delete();
		expAddr.delete();
		expData.delete();
	endtask

	task automatic emit(word_t instr);
		prog.push_back(instr);
	endtask

	task automatic expectStore(word_t addr, word_t data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	// sw rt, off(baseReg) plus its expected address and data
	task automatic storeAndExpect(regIdx_t rt, regIdx_t baseReg, word_t baseVal,
			logic [15:0] off, word_t value);
		emit(encodeI(OP_SW, rt, baseReg, off));
		expectStore(baseVal + signExtend(off), value);
	endtask

	// Done store, then spin on a self jump
	task automatic endProgram();
		emit(encodeI(OP_SW, 5'd0, 5'd0, DONE_ADDR[15:0]));
		expectStore(DONE_ADDR, 32'd0);
		emit(encodeJ(26'(prog.size())));
	endtask

	task automatic checkNoStoreInReset();
		if (memWrite) begin
			$display("Error: store strobe seen while reset is asserted");
			failures++;
		end
	endtask

	// Whole memory rewritten, program then fill
	task automatic loadProgram();
		for (int i = 0; i < MEM_WORDS; i++) begin
			memModel_i.loadWord(i, (i < prog.size()) ? prog[i] : fillWord(i));
			checkNoStoreInReset();
		end
		memModel_i.loadDone();
	endtask

	// Core idle in reset while memory loads, then the reset cycles proper
	task automatic resetCore();
		@(negedge cclk);
		rstb = 1'b0;
		loadProgram();
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge cclk);
			checkNoStoreInReset();
		end
		// This falling edge lies in the first fetch cycle
		@(negedge cclk);
		rstb = 1'b1;
	endtask

	// Samples mid-cycle, counts falling edges waited
	task automatic waitStore(output word_t addr, output word_t data, output int cycles,
			output bit found);
		found  = 1'b0;
		cycles = 0;
		addr   = '0;
		data   = '0;
		while (!found && cycles < STORE_TIMEOUT) begin
			@(negedge cclk);
			cycles++;
			if (memWrite) begin
				found = 1'b1;
				addr  = memAddr;
				data  = memWriteData;
			end
		end
	endtask

	// Collect stores up to the done store, compare in order
	task automatic runProgram(string testName);
		word_t gotAddr[$];
		word_t gotData[$];
		word_t addr;
		word_t data;
		int    cycles;
		bit    found;
		bit    done;
		resetCore();
		done = 1'b0;
		while (!done) begin
			waitStore(addr, data, cycles, found);
			if (!found) begin
				$display("Error: %s timed out waiting for a store", testName);
				failures++;
				done = 1'b1;
			end else begin
				gotAddr.push_back(addr);
				gotData.push_back(data);
				done = (addr == DONE_ADDR) || (gotAddr.size() >= MAX_STORES);
			end
		end
		if (gotAddr.size() != expAddr.size()) begin
			$display("Error: %s saw %0d stores where %0d were expected", testName,
				gotAddr.size(), expAddr.size());
			failures++;
		end
		for (int i = 0; i < gotAddr.size() && i < expAddr.size(); i++) begin
			checkAddr($sformatf("%s store %0d memAddr", testName, i), gotAddr[i], expAddr[i]);
			checkWord($sformatf("%s store %0d memWriteData", testName, i), gotData[i],
				expData[i]);
		end
	endtask

	task automatic testRegisterOps();
		logic [15:0] immA;
		logic [15:0] immB;
		word_t       a;
		word_t       b;
		immA = 16'h03E8;
		immB = 16'hFED4;
		a = signExtend(immA);
		b = signExtend(immB);
		clearProgram();
		emit(encodeI(OP_ADDI, 5'd1, 5'd0, immA));
		emit(encodeI(OP_ADDI, 5'd2, 5'd0, immB));
		// Base register for the result stores
		emit(encodeI(OP_ADDI, 5'd10, 5'd0, DATA_BASE[15:0]));
		emit(encodeR(FN_ADD, 5'd3, 5'd1, 5'd2));
		storeAndExpect(5'd3, 5'd10, DATA_BASE, 16'h0000, a + b);
		emit(encodeR(FN_SUB, 5'd4, 5'd1, 5'd2));
		storeAndExpect(5'd4, 5'd10, DATA_BASE, 16'h0004, a - b);
		emit(encodeR(FN_AND, 5'd5, 5'd1, 5'd2));
		storeAndExpect(5'd5, 5'd10, DATA_BASE, 16'h0008, a & b);
		emit(encodeR(FN_OR, 5'd6, 5'd1, 5'd2));
		storeAndExpect(5'd6, 5'd10, DATA_BASE, 16'h000C, a | b);
		emit(encodeR(FN_XOR, 5'd7, 5'd1, 5'd2));
		storeAndExpect(5'd7, 5'd10, DATA_BASE, 16'h0010, a ^ b);
		// Signed compare both ways
		emit(encodeR(FN_SLT, 5'd8, 5'd2, 5'd1));
		storeAndExpect(5'd8, 5'd10, DATA_BASE, 16'h0014, setLess(b, a));
		emit(encodeR(FN_SLT, 5'd9, 5'd1, 5'd2));
		storeAndExpect(5'd9, 5'd10, DATA_BASE, 16'h0018, setLess(a, b));
		endProgram();
		runProgram("register ops");
	endtask

	task automatic testImmediates();
		word_t v1;
		word_t v12;
		v1  = signExtend(16'h1357);
		v12 = signExtend(16'h8000);
		clearProgram();
		emit(encodeI(OP_ADDI, 5'd1, 5'd0, 16'h1357));
		emit(encodeI(OP_ADDI, 5'd12, 5'd0, 16'h8000));
		emit(encodeI(OP_SLTI, 5'd2, 5'd1, 16'h8421));
		storeAndExpect(5'd2, 5'd0, '0, 16'h0200, setLess(v1, signExtend(16'h8421)));
		emit(encodeI(OP_SLTI, 5'd13, 5'd12, 16'h8421));
		storeAndExpect(5'd13, 5'd0, '0, 16'h0204, setLess(v12, signExtend(16'h8421)));
		// Logical ops see the upper half cleared
		emit(encodeI(OP_ANDI, 5'd3, 5'd12, 16'h8421));
		storeAndExpect(5'd3, 5'd0, '0, 16'h0208, v12 & zeroExtend(16'h8421));
		emit(encodeI(OP_ORI, 5'd4, 5'd1, 16'h8421));
		storeAndExpect(5'd4, 5'd0, '0, 16'h020C, v1 | zeroExtend(16'h8421));
		emit(encodeI(OP_XORI, 5'd5, 5'd12, 16'hF0F0));
		storeAndExpect(5'd5, 5'd0, '0, 16'h0210, v12 ^ zeroExtend(16'hF0F0));
		emit(encodeI(OP_LUI, 5'd6, 5'd0, 16'hABCD));
		storeAndExpect(5'd6, 5'd0, '0, 16'h0214, {16'hABCD, 16'h0000});
		emit(encodeI(OP_ADDI, 5'd7, 5'd1, 16'h8421));
		storeAndExpect(5'd7, 5'd0, '0, 16'h0218, v1 + signExtend(16'h8421));
		endProgram();
		runProgram("immediates");
	endtask

	task automatic testLoadStore();
		word_t v;
		v = {16'hCAFE, 16'h0000} | zeroExtend(16'h1234);
		clearProgram();
		emit(encodeI(OP_LUI, 5'd1, 5'd0, 16'hCAFE));
		emit(encodeI(OP_ORI, 5'd1, 5'd1, 16'h1234));
		storeAndExpect(5'd1, 5'd0, '0, 16'h0220, v);
		emit(encodeI(OP_LW, 5'd2, 5'd0, 16'h0220));
		storeAndExpect(5'd2, 5'd0, '0, 16'h0224, v);
		// Negative offset from a base register
		emit(encodeI(OP_ADDI, 5'd3, 5'd0, 16'h0230));
		emit(encodeI(OP_LW, 5'd4, 5'd3, 16'hFFF0));
		// Full store address shows how the offset was extended
		storeAndExpect(5'd4, 5'd3, 32'h0000_0230, 16'hFFF8, v);
		endProgram();
		runProgram("load store");
	endtask

	task automatic testBranches();
		clearProgram();
		emit(encodeI(OP_ADDI, 5'd1, 5'd0, 16'd5));
		emit(encodeI(OP_ADDI, 5'd2, 5'd0, 16'd5));
		emit(encodeI(OP_ADDI, 5'd3, 5'd0, 16'd7));
		// One marker per path, 14 marks a wrong path
		emit(encodeI(OP_ADDI, 5'd10, 5'd0, 16'h00A1));
		emit(encodeI(OP_ADDI, 5'd11, 5'd0, 16'h00A2));
		emit(encodeI(OP_ADDI, 5'd12, 5'd0, 16'h00B1));
		emit(encodeI(OP_ADDI, 5'd13, 5'd0, 16'h00B2));
		emit(encodeI(OP_ADDI, 5'd14, 5'd0, 16'h0BAD));
		// Word 8, beq taken to word 11
		emit(encodeI(OP_BEQ, 5'd2, 5'd1, 16'd2));
		emit(encodeI(OP_SW, 5'd14, 5'd0, 16'h0240));
		emit(encodeI(OP_SW, 5'd14, 5'd0, 16'h0240));
		storeAndExpect(5'd10, 5'd0, '0, 16'h0240, signExtend(16'h00A1));
		// Word 12, beq not taken
		emit(encodeI(OP_BEQ, 5'd3, 5'd1, 16'd1));
		storeAndExpect(5'd11, 5'd0, '0, 16'h0244, signExtend(16'h00A2));
		// Word 14, bne taken to word 16
		emit(encodeI(OP_BNE, 5'd3, 5'd1, 16'd1));
		emit(encodeI(OP_SW, 5'd14, 5'd0, 16'h0248));
		storeAndExpect(5'd12, 5'd0, '0, 16'h0248, signExtend(16'h00B1));
		// Word 17, bne not taken
		emit(encodeI(OP_BNE, 5'd2, 5'd1, 16'd1));
		storeAndExpect(5'd13, 5'd0, '0, 16'h024C, signExtend(16'h00B2));
		endProgram();
		runProgram("branches");
	endtask

	task automatic testJumpAndZero();
		clearProgram();
		emit(encodeI(OP_ADDI, 5'd1, 5'd0, 16'h00C5));
		// Over the store at word 2
		emit(encodeJ(26'd3));
		emit(encodeI(OP_SW, 5'd1, 5'd0, 16'h0260));
		emit(encodeI(OP_ADDI, 5'd0, 5'd0, 16'h0123));
		storeAndExpect(5'd0, 5'd0, '0, 16'h0264, 32'd0);
		emit(encodeR(FN_ADD, 5'd0, 5'd1, 5'd1));
		storeAndExpect(5'd0, 5'd0, '0, 16'h0268, 32'd0);
		storeAndExpect(5'd1, 5'd0, '0, 16'h026C, signExtend(16'h00C5));
		endProgram();
		runProgram("jump and zero");
	endtask

	task automatic testResetTiming();
		word_t addr;
		word_t data;
		word_t expected;
		int    cycles;
		bit    found;
		expected = (signExtend(16'd3) + signExtend(16'd4)) | zeroExtend(16'h0010);
		clearProgram();
		emit(encodeI(OP_ADDI, 5'd1, 5'd0, 16'd3));
		emit(encodeI(OP_ADDI, 5'd2, 5'd0, 16'd4));
		emit(encodeR(FN_ADD, 5'd3, 5'd1, 5'd2));
		emit(encodeI(OP_ORI, 5'd4, 5'd3, 16'h0010));
		emit(encodeI(OP_SW, 5'd4, 5'd0, 16'h0280));
		emit(encodeJ(26'(prog.size())));
		resetCore();
		waitStore(addr, data, cycles, found);
		if (!found) begin
			$display("Error: timing program never produced its store");
			failures++;
		end else begin
			// Release edge was cycle 1, strobe in the last sw cycle
			checkCycles("sw strobe cycle", cycles + 1, 4 * CYC_ALU + CYC_SW);
			checkAddr("timing memAddr", addr, 32'h0000_0280);
			checkWord("timing memWriteData", data, expected);
			@(negedge cclk);
			if (memWrite) begin
				$display("Error: store strobe lasted more than one cycle");
				failures++;
			end
		end
	endtask

	initial begin
		rstb = 1'b0;
		testResetTiming();
		testRegisterOps();
		testImmediates();
		testLoadStore();
		testBranches();
		testJumpAndZero();
		$display("Checks %0d, mismatches %0d, other failures %0d", checks, mismatches,
			failures);
		if (mismatches == 0 && failures == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
design/mipsIsaPkg.sv
design/mipsCtrlPkg.sv
design/aluDecoder.sv
design/alu.sv
design/registerFile.sv
design/controlUnit.sv
design/datapath.sv
design/multicycleCpu.sv
verif/memModel.sv
verif/cpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module cpuTb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
	echo "Verilator build did not succeed"
	exit 1
fi

./obj_dir/VcpuTb > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
	exit 1
fi
exit 0
